//--- avmm_defs.svh
// Shared bus widths and memory depth for the split read/write memory bridge
`ifndef AVMM_DEFS_SVH
`define AVMM_DEFS_SVH

// Word address width on both the master channels and the memory bus
`define AVMM_ADDR_WIDTH 10

// Data word width
`define AVMM_DATA_WIDTH 32

// Burstcount width, so bursts run from 1 to 7 beats
`define AVMM_BURST_CNT_WIDTH 3

// Width of the user tag echoed back with each response
`define AVMM_USER_WIDTH 4

// Implemented words in the memory; word addresses at or above this are out of range
`define AVMM_MEM_DEPTH 256

// One byte enable per data byte
`define AVMM_N_BYTES (`AVMM_DATA_WIDTH / 8)

`endif

//--- avmm_types_pkg.sv
// Request payload structs and response codes carried through the memory bridge
`include "avmm_defs.svh"

package avmm_types_pkg;

    // One read command as it sits in the read request FIFO
    typedef struct packed {
        logic [`AVMM_ADDR_WIDTH-1:0] address;
        logic [`AVMM_BURST_CNT_WIDTH-1:0] burstcount;
        logic [`AVMM_N_BYTES-1:0] byteenable;
        logic [`AVMM_USER_WIDTH-1:0] user;
    } rd_req_t;

    // One write beat, with the burst's first address and length on every beat
    typedef struct packed {
        logic [`AVMM_ADDR_WIDTH-1:0] address;
        logic [`AVMM_BURST_CNT_WIDTH-1:0] burstcount;
        logic [`AVMM_DATA_WIDTH-1:0] data;
        logic [`AVMM_N_BYTES-1:0] byteenable;
        logic [`AVMM_USER_WIDTH-1:0] user;
        // Set on the final beat of the burst
        logic eop;
    } wr_req_t;

    // Avalon response encoding, only OKAY and SLVERR are produced here
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } avmm_resp_e;

endpackage

//--- mem_ctrl_pkg.sv
// State and client encodings for the arbiter and memory sequencing logic
`include "avmm_defs.svh"

package mem_ctrl_pkg;

    // Memory model sequencer states
    typedef enum logic [1:0] {
        MEM_IDLE        = 2'd0,
        MEM_READ_BURST  = 2'd1,
        MEM_WRITE_BURST = 2'd2
    } mem_state_e;

    // Arbiter client index, also used as the bit position in request and grant
    typedef enum logic {
        CLIENT_READ  = 1'b0,
        CLIENT_WRITE = 1'b1
    } arb_client_e;

endpackage

//--- avmm_mem_if.sv
// Single command bus between the read/write bridge and the burst memory
`include "avmm_defs.svh"

interface avmm_mem_if;
    import avmm_types_pkg::*;

    // Command side, driven by the bridge
    logic read;
    logic write;
    logic [`AVMM_ADDR_WIDTH-1:0] address;
    logic [`AVMM_BURST_CNT_WIDTH-1:0] burstcount;
    logic [`AVMM_DATA_WIDTH-1:0] writedata;
    logic [`AVMM_N_BYTES-1:0] byteenable;
    logic [`AVMM_USER_WIDTH-1:0] user;

    // Flow control and responses, driven by the memory
    logic waitrequest;
    logic [`AVMM_DATA_WIDTH-1:0] readdata;
    logic readdatavalid;
    avmm_resp_e response;
    logic [`AVMM_USER_WIDTH-1:0] readresponseuser;
    logic writeresponsevalid;
    avmm_resp_e writeresponse;
    logic [`AVMM_USER_WIDTH-1:0] writeresponseuser;

    // The bridge issues commands and consumes responses
    modport bridge
    (
        output read, write, address, burstcount, writedata, byteenable, user,
        input  waitrequest, readdata, readdatavalid, response, readresponseuser,
        input  writeresponsevalid, writeresponse, writeresponseuser
    );

    // The memory accepts commands and produces responses
    modport memory
    (
        input  read, write, address, burstcount, writedata, byteenable, user,
        output waitrequest, readdata, readdatavalid, response, readresponseuser,
        output writeresponsevalid, writeresponse, writeresponseuser
    );

endinterface

//--- burst_eop_tracker.sv
// Write burst tracker that marks the last accepted beat of every burst
`include "avmm_defs.svh"

module burst_eop_tracker
(
    input  logic clk,
    input  logic reset_n,
    input  logic beat_valid,
    input  logic [`AVMM_BURST_CNT_WIDTH-1:0] burstcount,
    output logic eop
);

    // Beats still owed after the current one; zero means the next beat starts a burst
    logic [`AVMM_BURST_CNT_WIDTH-1:0] beats_left;

    // A starting beat ends the burst only when the burst is one beat long
    assign eop = (beats_left == '0) ? (burstcount <= 1) : (beats_left == 1);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            beats_left <= '0;
        end
        else if (beat_valid)
        begin
            if (eop)
                beats_left <= '0;
            else if (beats_left == '0)
                // First beat of a longer burst, so load the rest of the count
                beats_left <= burstcount - 1'b1;
            else
                beats_left <= beats_left - 1'b1;
        end
    end

endmodule

//--- req_fifo2.sv
// Two-entry request FIFO with the head entry always visible
module req_fifo2
#(
    parameter int N_DATA_BITS = 32
)
(
    input  logic clk,
    input  logic reset_n,
    input  logic [N_DATA_BITS-1:0] enq_data,
    input  logic enq_en,
    output logic not_full,
    output logic [N_DATA_BITS-1:0] first,
    input  logic deq_en,
    output logic not_empty
);

    // Two storage slots addressed by one-bit pointers
    logic [N_DATA_BITS-1:0] slots [2];
    logic wr_ptr;
    logic rd_ptr;
    logic [1:0] count;

    // Full only when both slots are held
    assign not_full = (count != 2'd2);
    assign not_empty = (count != 2'd0);

    // The head comes straight from storage, so a new entry shows up a cycle after its write
    assign first = slots[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (enq_en)
            slots[wr_ptr] <= enq_data;
    end

    // Pointer and occupancy update, enqueue and dequeue may happen together
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count <= 2'd0;
        end
        else
        begin
            if (enq_en)
                wr_ptr <= ~wr_ptr;
            if (deq_en)
                rd_ptr <= ~rd_ptr;
            count <= count + {1'b0, enq_en} - {1'b0, deq_en};
        end
    end

endmodule

//--- rr_arbiter2.sv
// Round-robin arbiter between the read and write request queues
module rr_arbiter2
(
    input  logic clk,
    input  logic reset_n,
    input  logic ena,
    input  logic [1:0] request,
    output logic [1:0] grant
);
    import mem_ctrl_pkg::*;

    // Client that won the most recent grant
    arb_client_e last_winner;

    always_comb
    begin
        grant = '0;
        if (ena)
        begin
            if (request[CLIENT_READ] && request[CLIENT_WRITE])
            begin
                // On a tie the client that lost last time goes first
                if (last_winner == CLIENT_READ)
                    grant[CLIENT_WRITE] = 1'b1;
                else
                    grant[CLIENT_READ] = 1'b1;
            end
            else
            begin
                grant = request;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            last_winner <= CLIENT_WRITE;
        else if (grant[CLIENT_READ])
            last_winner <= CLIENT_READ;
        else if (grant[CLIENT_WRITE])
            last_winner <= CLIENT_WRITE;
    end

endmodule

//--- rdwr_to_mem_bridge.sv
// Bridge that queues split read/write requests and merges them onto one memory bus
`include "avmm_defs.svh"

module rdwr_to_mem_bridge
(
    input  logic clk,
    input  logic reset_n,
    input  logic rd_read,
    input  logic [`AVMM_ADDR_WIDTH-1:0] rd_address,
    input  logic [`AVMM_BURST_CNT_WIDTH-1:0] rd_burstcount,
    input  logic [`AVMM_N_BYTES-1:0] rd_byteenable,
    input  logic [`AVMM_USER_WIDTH-1:0] rd_user,
    output logic rd_waitrequest,
    output logic [`AVMM_DATA_WIDTH-1:0] rd_readdata,
    output logic rd_readdatavalid,
    output avmm_types_pkg::avmm_resp_e rd_response,
    output logic [`AVMM_USER_WIDTH-1:0] rd_readresponseuser,
    input  logic wr_write,
    input  logic [`AVMM_ADDR_WIDTH-1:0] wr_address,
    input  logic [`AVMM_BURST_CNT_WIDTH-1:0] wr_burstcount,
    input  logic [`AVMM_DATA_WIDTH-1:0] wr_writedata,
    input  logic [`AVMM_N_BYTES-1:0] wr_byteenable,
    input  logic [`AVMM_USER_WIDTH-1:0] wr_user,
    output logic wr_waitrequest,
    output logic wr_writeresponsevalid,
    output avmm_types_pkg::avmm_resp_e wr_response,
    output logic [`AVMM_USER_WIDTH-1:0] wr_writeresponseuser,
    avmm_mem_if.bridge mem
);
    import avmm_types_pkg::*;
    import mem_ctrl_pkg::*;

    rd_req_t rd_in;
    wr_req_t wr_in;
    rd_req_t rd_head;
    wr_req_t wr_head;
    logic rd_not_full;
    logic rd_not_empty;
    logic wr_not_full;
    logic wr_not_empty;
    logic [1:0] arb_request;
    logic [1:0] arb_grant;
    logic write_burst_active;

    // Pack the incoming channel signals into queue entries
    assign rd_in = '{address: rd_address, burstcount: rd_burstcount,
                     byteenable: rd_byteenable, user: rd_user};
    assign wr_in.address = wr_address;
    assign wr_in.burstcount = wr_burstcount;
    assign wr_in.data = wr_writedata;
    assign wr_in.byteenable = wr_byteenable;
    assign wr_in.user = wr_user;

    // Each channel stalls only when its own queue is full
    assign rd_waitrequest = !rd_not_full;
    assign wr_waitrequest = !wr_not_full;

    // Burst ends are found on accepted master beats and stored with each beat
    burst_eop_tracker eop_tracker
    (
        .clk,
        .reset_n,
        .beat_valid(wr_write && !wr_waitrequest),
        .burstcount(wr_burstcount),
        .eop(wr_in.eop)
    );

    req_fifo2 #(.N_DATA_BITS($bits(rd_req_t))) rd_fifo
    (
        .clk,
        .reset_n,
        .enq_data(rd_in),
        .enq_en(rd_read && !rd_waitrequest),
        .not_full(rd_not_full),
        .first(rd_head),
        .deq_en(mem.read),
        .not_empty(rd_not_empty)
    );

    req_fifo2 #(.N_DATA_BITS($bits(wr_req_t))) wr_fifo
    (
        .clk,
        .reset_n,
        .enq_data(wr_in),
        .enq_en(wr_write && !wr_waitrequest),
        .not_full(wr_not_full),
        .first(wr_head),
        .deq_en(mem.write),
        .not_empty(wr_not_empty)
    );

    assign arb_request[CLIENT_READ] = rd_not_empty;
    assign arb_request[CLIENT_WRITE] = wr_not_empty;

    // No new winner while the memory stalls or a write burst is part way through
    rr_arbiter2 arbiter
    (
        .clk,
        .reset_n,
        .ena(!mem.waitrequest && !write_burst_active),
        .request(arb_request),
        .grant(arb_grant)
    );

    // A write that wins, or any queued beat of a burst already under way, goes out now
    assign mem.read = arb_grant[CLIENT_READ];
    assign mem.write = arb_grant[CLIENT_WRITE] ||
                       (!mem.waitrequest && write_burst_active && wr_not_empty);

    // Held from the first issued beat of a burst until its eop beat is issued
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            write_burst_active <= 1'b0;
        else if (mem.write)
            write_burst_active <= !wr_head.eop;
    end

    // Bus fields follow the queue that owns the current command
    always_comb
    begin
        mem.address = mem.read ? rd_head.address : wr_head.address;
        mem.burstcount = mem.read ? rd_head.burstcount : wr_head.burstcount;
        mem.byteenable = mem.read ? rd_head.byteenable : wr_head.byteenable;
        mem.user = mem.read ? rd_head.user : wr_head.user;
        mem.writedata = wr_head.data;
    end

    // Read responses pass straight back to the master
    assign rd_readdata = mem.readdata;
    assign rd_readdatavalid = mem.readdatavalid;
    assign rd_response = mem.response;
    assign rd_readresponseuser = mem.readresponseuser;

    // Write responses take one register stage on the way back
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            wr_writeresponsevalid <= 1'b0;
        else
            wr_writeresponsevalid <= mem.writeresponsevalid;
    end

    always_ff @(posedge clk)
    begin
        wr_response <= mem.writeresponse;
        wr_writeresponseuser <= mem.writeresponseuser;
    end

endmodule

//--- burst_mem_model.sv
// Word-addressed burst memory that answers reads and writes with status and user echo
`include "avmm_defs.svh"

module burst_mem_model
(
    input  logic clk,
    input  logic reset_n,
    avmm_mem_if.memory mem
);
    import avmm_types_pkg::*;
    import mem_ctrl_pkg::*;

    localparam int IDX_W = $clog2(`AVMM_MEM_DEPTH);
    localparam logic [`AVMM_ADDR_WIDTH:0] DEPTH_LIMIT = `AVMM_MEM_DEPTH;

    logic [`AVMM_DATA_WIDTH-1:0] words [`AVMM_MEM_DEPTH];
    mem_state_e state;
    logic [`AVMM_BURST_CNT_WIDTH-1:0] beat_idx;
    logic wr_err;

    // Command fields held for the rest of a burst
    logic [`AVMM_ADDR_WIDTH-1:0] cmd_base;
    logic [`AVMM_BURST_CNT_WIDTH-1:0] cmd_count;
    logic [`AVMM_USER_WIDTH-1:0] cmd_user;

    logic [`AVMM_ADDR_WIDTH-1:0] cur_base;
    logic [`AVMM_BURST_CNT_WIDTH-1:0] cur_count;
    logic [`AVMM_USER_WIDTH-1:0] cur_user;
    logic [`AVMM_ADDR_WIDTH:0] cur_addr;
    logic [IDX_W-1:0] cur_idx;
    logic oob;
    logic last;
    logic write_beat;
    logic wr_done;

    // In idle the first write beat is taken from the bus, later beats from the held command
    assign cur_base = (state == MEM_IDLE) ? mem.address : cmd_base;
    assign cur_count = (state == MEM_IDLE) ? mem.burstcount : cmd_count;
    assign cur_user = (state == MEM_IDLE) ? mem.user : cmd_user;

    // One extra address bit so a burst running off the top is caught, not wrapped
    assign cur_addr = {1'b0, cur_base} + beat_idx;
    assign cur_idx = cur_addr[IDX_W-1:0];
    assign oob = (cur_addr >= DEPTH_LIMIT);
    // A zero burstcount is treated as a single beat
    assign last = ({1'b0, beat_idx} + 1'b1) >= {1'b0, cur_count};

    // Writes are taken whenever no read burst is streaming
    assign write_beat = mem.write && (state != MEM_READ_BURST);
    assign wr_done = write_beat && last;

    // Stall new commands for the whole read stream
    assign mem.waitrequest = (state == MEM_READ_BURST);

    // Read beats stream from storage, one per cycle, zero data past the end
    assign mem.readdatavalid = (state == MEM_READ_BURST);
    assign mem.readdata = oob ? '0 : words[cur_idx];
    assign mem.response = oob ? RESP_SLVERR : RESP_OKAY;
    assign mem.readresponseuser = cmd_user;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= MEM_IDLE;
            beat_idx <= '0;
            wr_err <= 1'b0;
            mem.writeresponsevalid <= 1'b0;
        end
        else
        begin
            mem.writeresponsevalid <= wr_done;
            // Collect range errors over a write burst, clear at its end
            if (write_beat)
                wr_err <= last ? 1'b0 : (wr_err || oob);

            case (state)
                MEM_IDLE:
                    if (mem.read)
                        state <= MEM_READ_BURST;
                    else if (mem.write && !last)
                    begin
                        state <= MEM_WRITE_BURST;
                        beat_idx <= beat_idx + 1'b1;
                    end
                MEM_READ_BURST, MEM_WRITE_BURST:
                    if (state == MEM_READ_BURST || mem.write)
                    begin
                        if (last)
                        begin
                            state <= MEM_IDLE;
                            beat_idx <= '0;
                        end
                        else
                        begin
                            beat_idx <= beat_idx + 1'b1;
                        end
                    end
                default:
                    state <= MEM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        // Latch the command every idle cycle, so an accepted one is held
        if (state == MEM_IDLE)
        begin
            cmd_base <= mem.address;
            cmd_count <= mem.burstcount;
            cmd_user <= mem.user;
        end

        // Merge in-range write data under byteenable, drop beats past the end
        if (write_beat && !oob)
        begin
            for (int b = 0; b < `AVMM_N_BYTES; b++)
            begin
                if (mem.byteenable[b])
                    words[cur_idx][b*8 +: 8] <= mem.writedata[b*8 +: 8];
            end
        end

        // One response per write burst, SLVERR if any beat fell out of range
        if (wr_done)
        begin
            mem.writeresponse <= (wr_err || oob) ? RESP_SLVERR : RESP_OKAY;
            mem.writeresponseuser <= cur_user;
        end
    end

endmodule

//--- avmm_rdwr_top.sv
// Top level joining the split-bus master ports to the burst memory through the bridge
`include "avmm_defs.svh"

module avmm_rdwr_top
(
    input  logic clk,
    input  logic reset_n,
    input  logic rd_read,
    input  logic [`AVMM_ADDR_WIDTH-1:0] rd_address,
    input  logic [`AVMM_BURST_CNT_WIDTH-1:0] rd_burstcount,
    input  logic [`AVMM_N_BYTES-1:0] rd_byteenable,
    input  logic [`AVMM_USER_WIDTH-1:0] rd_user,
    output logic rd_waitrequest,
    output logic [`AVMM_DATA_WIDTH-1:0] rd_readdata,
    output logic rd_readdatavalid,
    output avmm_types_pkg::avmm_resp_e rd_response,
    output logic [`AVMM_USER_WIDTH-1:0] rd_readresponseuser,
    input  logic wr_write,
    input  logic [`AVMM_ADDR_WIDTH-1:0] wr_address,
    input  logic [`AVMM_BURST_CNT_WIDTH-1:0] wr_burstcount,
    input  logic [`AVMM_DATA_WIDTH-1:0] wr_writedata,
    input  logic [`AVMM_N_BYTES-1:0] wr_byteenable,
    input  logic [`AVMM_USER_WIDTH-1:0] wr_user,
    output logic wr_waitrequest,
    output logic wr_writeresponsevalid,
    output avmm_types_pkg::avmm_resp_e wr_response,
    output logic [`AVMM_USER_WIDTH-1:0] wr_writeresponseuser
);

    // Single command bus between the bridge and the memory
    avmm_mem_if mem_bus ();

    // All master-side ports share their names with the bridge ports
    rdwr_to_mem_bridge bridge
    (
        .clk, .reset_n,
        .rd_read, .rd_address, .rd_burstcount, .rd_byteenable, .rd_user,
        .rd_waitrequest, .rd_readdata, .rd_readdatavalid, .rd_response,
        .rd_readresponseuser,
        .wr_write, .wr_address, .wr_burstcount, .wr_writedata, .wr_byteenable, .wr_user,
        .wr_waitrequest, .wr_writeresponsevalid, .wr_response, .wr_writeresponseuser,
        .mem(mem_bus.bridge)
    );

    burst_mem_model memory
    (
        .clk,
        .reset_n,
        .mem(mem_bus.memory)
    );

endmodule

//--- tb_avmm_rdwr.sv
// Self-checking testbench for the split read/write bridge and its burst memory
`include "avmm_defs.svh"

module tb_avmm_rdwr;
    import avmm_types_pkg::*;
    import mem_ctrl_pkg::*;

    // Cycles a single wait may take before the run is abandoned
    localparam int WAIT_LIMIT = 200;
    localparam int DRAIN_LIMIT = 2000;

    // One expected read data beat
    typedef struct packed {
        logic [`AVMM_DATA_WIDTH-1:0] data;
        avmm_resp_e resp;
        logic [`AVMM_USER_WIDTH-1:0] user;
    } rd_beat_t;

    // One expected write response, one per burst
    typedef struct packed {
        avmm_resp_e resp;
        logic [`AVMM_USER_WIDTH-1:0] user;
    } wr_resp_t;

    logic clk;
    logic reset_n;
    logic rd_read;
    logic [`AVMM_ADDR_WIDTH-1:0] rd_address;
    logic [`AVMM_BURST_CNT_WIDTH-1:0] rd_burstcount;
    logic [`AVMM_N_BYTES-1:0] rd_byteenable;
    logic [`AVMM_USER_WIDTH-1:0] rd_user;
    logic rd_waitrequest;
    logic [`AVMM_DATA_WIDTH-1:0] rd_readdata;
    logic rd_readdatavalid;
    avmm_resp_e rd_response;
    logic [`AVMM_USER_WIDTH-1:0] rd_readresponseuser;
    logic wr_write;
    logic [`AVMM_ADDR_WIDTH-1:0] wr_address;
    logic [`AVMM_BURST_CNT_WIDTH-1:0] wr_burstcount;
    logic [`AVMM_DATA_WIDTH-1:0] wr_writedata;
    logic [`AVMM_N_BYTES-1:0] wr_byteenable;
    logic [`AVMM_USER_WIDTH-1:0] wr_user;
    logic wr_waitrequest;
    logic wr_writeresponsevalid;
    avmm_resp_e wr_response;
    logic [`AVMM_USER_WIDTH-1:0] wr_writeresponseuser;

    // Expected responses in issue order with one queue per channel
    rd_beat_t rd_exp_q [$];
    wr_resp_t wr_exp_q [$];
    rd_beat_t rd_exp_beat;
    wr_resp_t wr_exp_resp;

    // Reference copy of the implemented words
    logic [`AVMM_DATA_WIDTH-1:0] ref_mem [`AVMM_MEM_DEPTH];

    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int test_err_start = 0;
    int rd_beats_issued = 0;
    int rd_beats_seen = 0;
    int wr_bursts_issued = 0;
    int wr_resps_seen = 0;
    logic rd_wait_seen = 1'b0;

    avmm_rdwr_top UUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Fill value built from every address bit, so a misplaced word shows up
    function automatic logic [`AVMM_DATA_WIDTH-1:0] fill_word(int addr);
        logic [9:0] a;
        a = addr[9:0];
        return {6'h2a, a, 6'h15, ~a};
    endfunction

    function void report_value(string name, logic [31:0] exp, logic [31:0] act);
        errors++;
        $display("Error at time %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
    endfunction

    function void report_failure(string what);
        errors++;
        $display("Check failed at time %0t: %s", $time, what);
    endfunction

    task automatic abort_run(string why);
        $display("Timeout at time %0t: %s", $time, why);
        $display("Tests run: %0d, tests with errors: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        $display("Testbench failed");
        $finish;
    endtask

    // Responses are checked at the falling edge after the outputs have settled
    always @(negedge clk)
    begin
        if (reset_n)
        begin
            if (rd_waitrequest)
                rd_wait_seen = 1'b1;
            if (rd_readdatavalid)
            begin
                rd_beats_seen++;
                checks++;
                assert (rd_exp_q.size() > 0)
                else
                    report_failure("read data beat arrived with no read outstanding");
                if (rd_exp_q.size() > 0)
                begin
                    rd_exp_beat = rd_exp_q.pop_front();
                    assert (rd_readdata === rd_exp_beat.data)
                    else
                        report_value("rd_readdata", rd_exp_beat.data, rd_readdata);
                    assert (rd_response === rd_exp_beat.resp)
                    else
                        report_value("rd_response", rd_exp_beat.resp, rd_response);
                    assert (rd_readresponseuser === rd_exp_beat.user)
                    else
                        report_value("rd_readresponseuser", rd_exp_beat.user,
                                     rd_readresponseuser);
                end
            end
            if (wr_writeresponsevalid)
            begin
                wr_resps_seen++;
                checks++;
                assert (wr_exp_q.size() > 0)
                else
                    report_failure("write response arrived with no write burst outstanding");
                if (wr_exp_q.size() > 0)
                begin
                    wr_exp_resp = wr_exp_q.pop_front();
                    assert (wr_response === wr_exp_resp.resp)
                    else
                        report_value("wr_response", wr_exp_resp.resp, wr_response);
                    assert (wr_writeresponseuser === wr_exp_resp.user)
                    else
                        report_value("wr_writeresponseuser", wr_exp_resp.user,
                                     wr_writeresponseuser);
                end
            end
        end
    end

    // Drives one read command and queues the beats the range rule predicts for it
    task automatic read_burst(input int addr, input int len);
        logic [`AVMM_USER_WIDTH-1:0] user;
        rd_beat_t beat;
        int waited;
        user = `AVMM_USER_WIDTH'($urandom);
        @(negedge clk);
        rd_read = 1'b1;
        rd_address = `AVMM_ADDR_WIDTH'(addr);
        rd_burstcount = `AVMM_BURST_CNT_WIDTH'(len);
        rd_byteenable = `AVMM_N_BYTES'($urandom);
        rd_user = user;
        waited = 0;
        while (rd_waitrequest)
        begin
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run("read request never accepted, rd_waitrequest stayed high");
            @(negedge clk);
        end
        // The command transfers on the coming rising edge
        for (int i = 0; i < len; i++)
        begin
            beat.user = user;
            if (addr + i < `AVMM_MEM_DEPTH)
            begin
                beat.data = ref_mem[addr + i];
                beat.resp = RESP_OKAY;
            end
            else
            begin
                beat.data = '0;
                beat.resp = RESP_SLVERR;
            end
            rd_exp_q.push_back(beat);
        end
        rd_beats_issued += len;
    endtask

    task automatic read_idle();
        @(negedge clk);
        rd_read = 1'b0;
    endtask

    // Drives one write burst, beat by beat, and keeps the reference memory in step
    task automatic write_burst(input int addr, input int len, input bit fill);
        logic [`AVMM_USER_WIDTH-1:0] user;
        logic [`AVMM_DATA_WIDTH-1:0] data;
        logic [`AVMM_N_BYTES-1:0] be;
        wr_resp_t resp;
        bit burst_err;
        int waited;
        user = `AVMM_USER_WIDTH'($urandom);
        burst_err = 1'b0;
        for (int i = 0; i < len; i++)
        begin
            data = fill ? fill_word(addr + i) : $urandom;
            be = fill ? '1 : `AVMM_N_BYTES'($urandom);
            @(negedge clk);
            wr_write = 1'b1;
            // Every beat repeats the first address and the burst length
            wr_address = `AVMM_ADDR_WIDTH'(addr);
            wr_burstcount = `AVMM_BURST_CNT_WIDTH'(len);
            wr_writedata = data;
            wr_byteenable = be;
            wr_user = user;
            waited = 0;
            while (wr_waitrequest)
            begin
                waited++;
                if (waited > WAIT_LIMIT)
                    abort_run("write beat never accepted, wr_waitrequest stayed high");
                @(negedge clk);
            end
            if (addr + i < `AVMM_MEM_DEPTH)
            begin
                for (int b = 0; b < `AVMM_N_BYTES; b++)
                begin
                    if (be[b])
                        ref_mem[addr + i][b*8 +: 8] = data[b*8 +: 8];
                end
            end
            else
            begin
                burst_err = 1'b1;
            end
        end
        resp.resp = burst_err ? RESP_SLVERR : RESP_OKAY;
        resp.user = user;
        wr_exp_q.push_back(resp);
        wr_bursts_issued++;
    endtask

    task automatic write_idle();
        @(negedge clk);
        wr_write = 1'b0;
    endtask

    // Waits until every expected response has arrived, then checks the totals
    task automatic wait_drained();
        int waited;
        waited = 0;
        while (rd_exp_q.size() != 0 || wr_exp_q.size() != 0)
        begin
            waited++;
            if (waited > DRAIN_LIMIT)
                abort_run("responses still outstanding after the drain limit");
            @(negedge clk);
        end
        // A few quiet cycles so a duplicated beat or response is still caught
        repeat (4) @(negedge clk);
        checks += 2;
        assert (rd_beats_seen == rd_beats_issued)
        else
            report_value("read beat count", rd_beats_issued, rd_beats_seen);
        assert (wr_resps_seen == wr_bursts_issued)
        else
            report_value("write response count", wr_bursts_issued, wr_resps_seen);
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (errors == test_err_start)
        begin
            $display("%s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - test_err_start);
        end
        test_err_start = errors;
    endtask

    task automatic idle_after_reset();
        for (int i = 0; i < 8; i++)
        begin
            @(negedge clk);
            checks++;
            assert (!rd_readdatavalid && !wr_writeresponsevalid)
            else
                report_failure("a response valid was high with no traffic after reset");
            assert (!rd_waitrequest && !wr_waitrequest)
            else
                report_failure("a waitrequest was high with no traffic after reset");
            assert (!UUT.mem_bus.read && !UUT.mem_bus.write)
            else
                report_failure("the memory bus carried a command with no traffic");
            assert (UUT.memory.state == MEM_IDLE)
            else
                report_failure("the memory left its idle state with no traffic");
        end
    endtask

    task automatic single_writes_then_reads();
        int addrs [8];
        for (int i = 0; i < 8; i++)
        begin
            addrs[i] = $urandom_range(`AVMM_MEM_DEPTH - 1);
            write_burst(addrs[i], 1, 1'b0);
        end
        write_idle();
        wait_drained();
        for (int i = 0; i < 8; i++)
            read_burst(addrs[i], 1);
        read_idle();
        wait_drained();
    endtask

    task automatic bursts_read_back();
        int addr;
        addr = 64;
        for (int len = 1; len <= 7; len++)
            write_burst(addr + (len - 1) * len / 2, len, 1'b0);
        write_idle();
        wait_drained();
        // Same regions read back with matching lengths
        for (int len = 1; len <= 7; len++)
            read_burst(addr + (len - 1) * len / 2, len);
        read_idle();
        wait_drained();
    endtask

    task automatic concurrent_streams();
        fork
            begin
                // Reads stay below word 64 and writes stay between 128 and 191
                for (int i = 0; i < 10; i++)
                    read_burst($urandom_range(56), $urandom_range(7, 1));
                read_idle();
            end
            begin
                for (int i = 0; i < 10; i++)
                    write_burst(128 + $urandom_range(56), $urandom_range(7, 1), 1'b0);
                write_idle();
            end
        join
        wait_drained();
    endtask

    task automatic saturate_reads();
        rd_wait_seen = 1'b0;
        for (int i = 0; i < 8; i++)
            read_burst($urandom_range(`AVMM_MEM_DEPTH - 7), 7);
        read_idle();
        wait_drained();
        checks++;
        assert (rd_wait_seen)
        else
            report_failure("rd_waitrequest never rose under back-to-back long reads");
    endtask

    task automatic out_of_range();
        // Four beats land in range and three fall past the top
        write_burst(`AVMM_MEM_DEPTH - 4, 7, 1'b0);
        write_burst(300, 1, 1'b0);
        write_idle();
        wait_drained();
        read_burst(`AVMM_MEM_DEPTH - 4, 7);
        read_burst(300, 1);
        // Low words that the dropped beats would hit if the word index wrapped
        read_burst(0, 3);
        read_burst(300 - `AVMM_MEM_DEPTH, 1);
        read_idle();
        wait_drained();
    endtask

    initial
    begin
        void'($urandom(11946));
        reset_n = 1'b0;
        rd_read = 1'b0;
        rd_address = '0;
        rd_burstcount = '0;
        rd_byteenable = '0;
        rd_user = '0;
        wr_write = 1'b0;
        wr_address = '0;
        wr_burstcount = '0;
        wr_writedata = '0;
        wr_byteenable = '0;
        wr_user = '0;
        repeat (8) @(negedge clk);
        reset_n = 1'b1;

        idle_after_reset();
        end_test("test 1 idle after reset");

        // Load every word once so all later reads have known contents
        for (int a = 0; a < `AVMM_MEM_DEPTH; a += 7)
            write_burst(a, (`AVMM_MEM_DEPTH - a < 7) ? `AVMM_MEM_DEPTH - a : 7, 1'b1);
        write_idle();
        wait_drained();
        test_err_start = errors;

        single_writes_then_reads();
        end_test("test 2 single writes then reads");
        bursts_read_back();
        end_test("test 3 bursts read back");
        concurrent_streams();
        end_test("test 4 concurrent read and write streams");
        saturate_reads();
        end_test("test 5 read back-pressure");
        out_of_range();
        end_test("test 6 out-of-range accesses");

        $display("Tests run: %0d, tests with errors: %0d, checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
avmm_types_pkg.sv
mem_ctrl_pkg.sv
avmm_mem_if.sv
burst_eop_tracker.sv
req_fifo2.sv
rr_arbiter2.sv
rdwr_to_mem_bridge.sv
burst_mem_model.sv
avmm_rdwr_top.sv
tb_avmm_rdwr.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the memory bridge testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_avmm_rdwr -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log

grep -q "Testbench failed" sim.log && { echo "Result: FAIL"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "Result: no pass line in the log"; exit 1; }
echo "Result: PASS"
